// File: Makefile
# Verilator build and run of the SDMAC core testbench
VERILATOR ?= verilator
TOP       ?= sdmac_core_tb
FILELIST  ?= sdmac_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/sdmac_addr_decoder.sv
// ======================================================================
// CPU access decoder for the SDMAC register block
// An access starts on the first clock with cs_ and as_ low after as_
// was high, so as_ must return high between accesses
// Action strobes fire on reads and writes alike
// Unmapped offsets raise no strobe
// ======================================================================
module sdmac_addr_decoder (
  input  logic                      ACR_WR,
  input  logic                      RST_,
  input  logic [7:0]                addr,
  input  logic                      cs_,
  input  logic                      as_,
  input  logic                      rw,
  output sdmac_reg_pkg::reg_strb_t  strb
);

  logic as_q;  // as_ one clock back
  logic start; // First cycle of an access

  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      as_q <= 1'b1; // Bus idle out of reset
    end else begin
      as_q <= as_;
    end
  end

  assign start = !cs_ && !as_ && as_q;

  // One strobe per access, chosen by offset and direction
  always_comb begin
    strb = '0;
    if (start) begin
      case (addr)
        sdmac_reg_pkg::cntr_addr: begin
          strb.cntr_rd = rw;
          strb.cntr_wr = !rw;
        end
        sdmac_reg_pkg::acr_addr:     strb.acr_wr  = !rw; // Write only
        sdmac_reg_pkg::st_dma_addr:  strb.st_dma  = 1'b1;
        sdmac_reg_pkg::sp_dma_addr:  strb.sp_dma  = 1'b1;
        sdmac_reg_pkg::flush_addr:   strb.flush   = 1'b1;
        sdmac_reg_pkg::clr_int_addr: strb.clr_int = 1'b1;
        sdmac_reg_pkg::istr_addr:    strb.istr_rd = rw;  // Read only
        sdmac_reg_pkg::data_addr:    strb.data_wr = !rw; // Data port push
        default: strb = '0;
      endcase
    end
  end

  // Never two register actions from one access
  a_one_strobe: assert property (@(posedge ACR_WR) disable iff (!RST_)
    $onehot0(strb))
    else $error("Decoder raised more than one register strobe");

endmodule

// File: hdl/sdmac_core.sv
// ======================================================================
// SDMAC host-to-SCSI DMA core, single clock ACR_WR, async reset RST_
// fifo_depth must be a power of two from 2 to 16
// End of a transfer is flagged by ISTR int_p and the int_ output
// ======================================================================
module sdmac_core #(
  parameter int fifo_depth = 8
) (
  input  logic                  ACR_WR,
  input  logic                  RST_,
  input  logic [7:0]            addr,
  input  logic                  cs_,
  input  logic                  as_,
  input  logic                  rw,
  input  sdmac_xfer_pkg::word_t wdata,
  input  logic                  scsi_rdy,
  output sdmac_xfer_pkg::word_t rdata,
  output sdmac_xfer_pkg::byte_t scsi_data,
  output logic                  scsi_strb,
  output logic                  preset,
  output logic                  int_
);

  logic                       push;
  logic                       pop;
  logic                       flush_req;
  logic                       dmaena;
  logic                       a1;
  logic                       a1_load;
  logic                       idle;
  sdmac_xfer_pkg::word_t      push_data;
  sdmac_xfer_pkg::word_t      pop_data;
  sdmac_xfer_pkg::fifo_stat_t fifo_stat;

  // Producer, host register block
  sdmac_registers u_registers (
    .ACR_WR    (ACR_WR),
    .RST_      (RST_),
    .addr      (addr),
    .cs_       (cs_),
    .as_       (as_),
    .rw        (rw),
    .wdata     (wdata),
    .fifo_stat (fifo_stat),
    .idle      (idle),
    .rdata     (rdata),
    .push      (push),
    .push_data (push_data),
    .flush_req (flush_req),
    .dmaena    (dmaena),
    .a1        (a1),
    .a1_load   (a1_load),
    .preset    (preset),
    .int_      (int_)
  );

  // Buffer
  sdmac_fifo #(
    .fifo_depth (fifo_depth)
  ) u_fifo (
    .ACR_WR    (ACR_WR),
    .RST_      (RST_),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .flush_req (flush_req),
    .pop_data  (pop_data),
    .fifo_stat (fifo_stat)
  );

  // Consumer, SCSI byte port
  sdmac_scsi_drain u_scsi_drain (
    .ACR_WR    (ACR_WR),
    .RST_      (RST_),
    .pop_data  (pop_data),
    .fifo_stat (fifo_stat),
    .dmaena    (dmaena),
    .a1        (a1),
    .a1_load   (a1_load),
    .scsi_rdy  (scsi_rdy),
    .pop       (pop),
    .scsi_data (scsi_data),
    .scsi_strb (scsi_strb),
    .idle      (idle)
  );

endmodule

// File: hdl/sdmac_fifo.sv
// ======================================================================
// Word FIFO between the register block and the SCSI drain
// fifo_depth must be a power of two from 2 to 16
// Head word is valid only while not empty
// Flush clears pointers and count in one cycle
// Push when full and pop when empty are illegal
// ======================================================================
module sdmac_fifo #(
  parameter int fifo_depth = 8
) (
  input  logic                       ACR_WR,
  input  logic                       RST_,
  input  logic                       push,
  input  sdmac_xfer_pkg::word_t      push_data,
  input  logic                       pop,
  input  logic                       flush_req,
  output sdmac_xfer_pkg::word_t      pop_data,
  output sdmac_xfer_pkg::fifo_stat_t fifo_stat
);

  localparam int aw = $clog2(fifo_depth); // Pointer width

  sdmac_xfer_pkg::word_t     mem [fifo_depth];
  logic [aw-1:0]             wr_ptr;
  logic [aw-1:0]             rd_ptr;
  sdmac_xfer_pkg::fifo_cnt_t count;

  // Payload storage
  always_ff @(posedge ACR_WR) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_req) begin // Drop everything at once
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1; // Wraps since depth is a power of two
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;         // Both or neither
      endcase
    end
  end

  assign pop_data        = mem[rd_ptr];
  assign fifo_stat.empty = (count == '0);
  assign fifo_stat.full  = (count == fifo_depth);
  assign fifo_stat.count = count;

  a_no_overflow: assert property (@(posedge ACR_WR) disable iff (!RST_)
    push |-> !fifo_stat.full)
    else $error("FIFO push while full");

  a_no_underflow: assert property (@(posedge ACR_WR) disable iff (!RST_)
    pop |-> !fifo_stat.empty)
    else $error("FIFO pop while empty");

endmodule

// File: hdl/sdmac_reg_pkg.sv
// ======================================================================
// Register map and register-level types of the SDMAC host interface
// Offsets are byte addresses of long words on the 8-bit CPU address
// Only the host-to-SCSI direction is implemented, dir is stored only
// ======================================================================
package sdmac_reg_pkg;

  // Register offsets
  localparam logic [7:0] cntr_addr    = 8'h08; // Control, read/write
  localparam logic [7:0] acr_addr     = 8'h0C; // Address control, write only
  localparam logic [7:0] st_dma_addr  = 8'h10; // Start DMA strobe
  localparam logic [7:0] flush_addr   = 8'h14; // Flush FIFO strobe
  localparam logic [7:0] clr_int_addr = 8'h18; // Clear interrupt strobe
  localparam logic [7:0] istr_addr    = 8'h1C; // Interrupt status, read only
  localparam logic [7:0] sp_dma_addr  = 8'h3C; // Stop DMA strobe
  localparam logic [7:0] data_addr    = 8'h40; // Data port, write only

  // Control register, bit 5 down to bit 0
  typedef struct packed {
    logic spare5;
    logic preset; // Peripheral reset out
    logic spare3;
    logic intena; // Interrupt enable
    logic dir;    // Transfer direction, not acted on
    logic spare0;
  } cntr_t;

  // Interrupt status register, bit 8 down to bit 0
  typedef struct packed {
    logic       int_p;    // Interrupt pending
    logic [2:0] rsvd_hi;  // Read as zero
    logic       dma_on;   // DMA enabled
    logic       flushing; // Flush in progress
    logic       rsvd_lo;  // Read as zero
    logic       ff;       // FIFO full
    logic       fe;       // FIFO empty
  } istr_t;

  // One-cycle strobes from the address decoder
  typedef struct packed {
    logic cntr_wr;
    logic acr_wr;
    logic st_dma;
    logic sp_dma;
    logic flush;
    logic clr_int;
    logic data_wr;
    logic cntr_rd;
    logic istr_rd;
  } reg_strb_t;

endpackage

// File: hdl/sdmac_registers.sv
// ======================================================================
// SDMAC register block as the host side producer of the DMA path
// Writes land on the edge that ends the strobe cycle
// rdata is combinational and zero outside a read of CNTR or ISTR
// Host must not write the data port while ISTR shows the FIFO full
// ======================================================================
module sdmac_registers (
  input  logic                       ACR_WR,
  input  logic                       RST_,
  input  logic [7:0]                 addr,
  input  logic                       cs_,
  input  logic                       as_,
  input  logic                       rw,
  input  sdmac_xfer_pkg::word_t      wdata,
  input  sdmac_xfer_pkg::fifo_stat_t fifo_stat,
  input  logic                       idle,      // Drain holds no bytes
  output sdmac_xfer_pkg::word_t      rdata,
  output logic                       push,
  output sdmac_xfer_pkg::word_t      push_data,
  output logic                       flush_req,
  output logic                       dmaena,
  output logic                       a1,
  output logic                       a1_load,
  output logic                       preset,
  output logic                       int_
);

  sdmac_reg_pkg::reg_strb_t strb;
  sdmac_reg_pkg::cntr_t     cntr;
  sdmac_reg_pkg::istr_t     istr;
  logic                     flushing;
  logic                     int_p;
  logic                     int_set; // Transfer done condition

  sdmac_addr_decoder u_addr_decoder (
    .ACR_WR (ACR_WR),
    .RST_   (RST_),
    .addr   (addr),
    .cs_    (cs_),
    .as_    (as_),
    .rw     (rw),
    .strb   (strb)
  );

  // DMA enabled, FIFO drained and nothing left in the drain
  assign int_set = dmaena && fifo_stat.empty && idle;

  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      cntr     <= '0;
      a1       <= 1'b0;
      a1_load  <= 1'b0;
      dmaena   <= 1'b0;
      flushing <= 1'b0;
      int_p    <= 1'b0;
    end else begin
      if (strb.cntr_wr) cntr <= wdata[5:0];
      if (strb.acr_wr)  a1   <= wdata[25]; // A1 of the start address
      a1_load  <= strb.acr_wr;             // Drain sees a1 already updated
      if (strb.st_dma)      dmaena <= 1'b1;
      else if (strb.sp_dma) dmaena <= 1'b0;
      flushing <= strb.flush;              // High for one cycle after flush
      int_p    <= int_set || (int_p && !strb.clr_int); // Set beats clear
    end
  end

  // Status view for the host
  always_comb begin
    istr          = '0;
    istr.int_p    = int_p;
    istr.dma_on   = dmaena;
    istr.flushing = flushing;
    istr.ff       = fifo_stat.full;
    istr.fe       = fifo_stat.empty;
  end

  // Read mux follows the whole read cycle, not just the strobe
  always_comb begin
    rdata = '0;
    if (!cs_ && !as_ && rw) begin
      case (addr)
        sdmac_reg_pkg::cntr_addr: rdata = {26'd0, cntr};
        sdmac_reg_pkg::istr_addr: rdata = {23'd0, istr};
        default:                  rdata = '0;
      endcase
    end
  end

  assign push      = strb.data_wr;
  assign push_data = wdata;
  assign flush_req = strb.flush;
  assign preset    = cntr.preset;
  assign int_      = !(int_p && cntr.intena); // Active low interrupt out

  // Host flow control relies on ff
  a_no_push_full: assert property (@(posedge ACR_WR) disable iff (!RST_)
    strb.data_wr |-> !fifo_stat.full)
    else $error("Data port written while FIFO full");

endmodule

// File: hdl/sdmac_scsi_drain.sv
// ======================================================================
// SCSI side drain, unloads FIFO words as bytes, most significant first
// After an ACR write with A1 set the next word gives only bytes 1 and 0
// Stopping DMA keeps the held word for a later start
// scsi_data is meaningful only in cycles with scsi_strb high
// ======================================================================
module sdmac_scsi_drain (
  input  logic                       ACR_WR,
  input  logic                       RST_,
  input  sdmac_xfer_pkg::word_t      pop_data,
  input  sdmac_xfer_pkg::fifo_stat_t fifo_stat,
  input  logic                       dmaena,
  input  logic                       a1,
  input  logic                       a1_load,
  input  logic                       scsi_rdy,
  output logic                       pop,
  output sdmac_xfer_pkg::byte_t      scsi_data,
  output logic                       scsi_strb,
  output logic                       idle
);

  sdmac_xfer_pkg::word_t word_q;   // Word being sent
  logic [1:0]            ptr;      // Next byte, 3 is the MSB
  logic                  full_q;   // Bytes still held
  logic                  a1_pend;  // Next word starts at byte 1
  logic                  a1_now;   // Pending including this cycle's load
  logic                  emit;
  logic                  last;     // Final byte of the held word

  assign emit   = full_q && dmaena && scsi_rdy;
  assign last   = emit && (ptr == 2'd0);
  assign a1_now = a1_pend || (a1_load && a1);

  // Refill when empty-handed or on the last byte, so words run back to back
  assign pop = dmaena && !fifo_stat.empty && (!full_q || last);

  always_ff @(posedge ACR_WR) begin
    if (pop) begin
      word_q <= pop_data;
    end
  end

  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      ptr     <= 2'd3;
      full_q  <= 1'b0;
      a1_pend <= 1'b0;
    end else begin
      if (pop) begin
        ptr     <= a1_now ? 2'd1 : 2'd3; // Skip upper half on odd word start
        full_q  <= 1'b1;
        a1_pend <= 1'b0;                 // Only the first word is affected
      end else begin
        if (a1_load) a1_pend <= a1;
        if (emit) begin
          if (ptr == 2'd0) full_q <= 1'b0; // Word done, nothing queued
          else             ptr    <= ptr - 2'd1;
        end
      end
    end
  end

  assign scsi_strb = emit;
  assign scsi_data = word_q[{ptr, 3'b000} +: 8];
  assign idle      = !full_q;

  // No SCSI traffic with DMA off
  a_strb_dma: assert property (@(posedge ACR_WR) disable iff (!RST_)
    scsi_strb |-> dmaena)
    else $error("scsi_strb high while DMA disabled");

endmodule

// File: hdl/sdmac_xfer_pkg.sv
// ======================================================================
// Data path types shared by the FIFO, the register block and the drain
// FIFO count is sized for the largest supported depth of 16 words
// ======================================================================
package sdmac_xfer_pkg;

  // Host data word, big-endian byte order on the SCSI side
  typedef logic [31:0] word_t;

  // SCSI side byte
  typedef logic [7:0] byte_t;

  // Largest FIFO depth the status count can express
  localparam int fifo_max_depth = 16;

  // Occupancy, 0 to fifo_max_depth inclusive
  typedef logic [$clog2(fifo_max_depth):0] fifo_cnt_t;

  // FIFO status seen by producer and consumer
  typedef struct packed {
    logic      empty; // No words held
    logic      full;  // Depth reached, pushes must stop
    fifo_cnt_t count; // Words held
  } fifo_stat_t;

endpackage

// File: sdmac_core.f
hdl/sdmac_reg_pkg.sv
hdl/sdmac_xfer_pkg.sv
hdl/sdmac_addr_decoder.sv
hdl/sdmac_registers.sv
hdl/sdmac_fifo.sv
hdl/sdmac_scsi_drain.sv
hdl/sdmac_core.sv
testbench/tb_clock.sv
testbench/sdmac_core_tb.sv

// File: testbench/sdmac_core_tb.sv
// ======================================================================
// Directed testbench for the SDMAC host-to-SCSI DMA core
// Host bus and scsi_rdy are driven on the falling edge from one process
// Bytes are collected at the rising edge and matched against a model
// Data words and the scsi_rdy pattern come from a Galois LFSR seeded 83
// ======================================================================
module sdmac_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int fifo_depth  = 8;
  localparam int word_cycles = 24;  // Two bus accesses plus four slow bytes
  localparam int bus_cycles  = 400; // Register traffic outside the streams
  localparam int cycle_limit = 2 * (bus_cycles + (2 * fifo_depth + 6) * word_cycles);

  logic                  ACR_WR;
  logic                  RST_;
  logic [7:0]            addr;
  logic                  cs_;
  logic                  as_;
  logic                  rw;
  sdmac_xfer_pkg::word_t wdata;
  logic                  scsi_rdy;
  sdmac_xfer_pkg::word_t rdata;
  sdmac_xfer_pkg::byte_t scsi_data;
  logic                  scsi_strb;
  logic                  preset;
  logic                  int_;

  logic [15:0]           lfsr;       // Shared random source
  logic                  rdy_random; // Take scsi_rdy from the LFSR instead of holding it high
  int                    cycles = 0;
  int                    err_val = 0;
  int                    err_other = 0;
  sdmac_xfer_pkg::byte_t rx_q[$];    // Bytes seen on the SCSI port
  sdmac_xfer_pkg::byte_t model_q[$]; // Bytes expected on the SCSI port

  tb_clock clk_gen (.ACR_WR(ACR_WR), .RST_(RST_));

  sdmac_core #(.fifo_depth(fifo_depth)) sdmac_core_inst (
    .ACR_WR(ACR_WR), .RST_(RST_), .addr(addr), .cs_(cs_), .as_(as_), .rw(rw),
    .wdata(wdata), .scsi_rdy(scsi_rdy), .rdata(rdata), .scsi_data(scsi_data),
    .scsi_strb(scsi_strb), .preset(preset), .int_(int_)
  );

  // Collect each strobed byte while strobe and data are settled before the edge
  always @(posedge ACR_WR) begin
    if (RST_ && scsi_strb) rx_q.push_back(scsi_data);
  end

  always @(posedge ACR_WR) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout, run passed %0d cycles; errors: %0d value, %0d other",
               cycle_limit, err_val, err_other);
      $display("Simulation failed");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output sdmac_xfer_pkg::word_t v);
    v = '0;
    repeat (n) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Expected ISTR word with int_p at bit 8 down to fe at bit 0
  function automatic sdmac_xfer_pkg::word_t istr_exp(input bit int_p, dma_on, flushing,
                                                     ff, fe);
    return {23'd0, int_p, 3'b000, dma_on, flushing, 1'b0, ff, fe};
  endfunction

  task automatic next_cycle();
    sdmac_xfer_pkg::word_t b;
    @(negedge ACR_WR);
    if (rdy_random) begin
      take_bits(1, b);
      scsi_rdy = b[0];
    end else begin
      scsi_rdy = 1'b1;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  // as_ low for two cycles, high for one
  task automatic cpu_write(input logic [7:0] a, input sdmac_xfer_pkg::word_t d);
    addr  = a;
    wdata = d;
    rw    = 1'b0;
    cs_   = 1'b0;
    as_   = 1'b0;
    idle_cycles(2);
    cs_ = 1'b1;
    as_ = 1'b1;
    rw  = 1'b1;
    next_cycle();
  endtask

  task automatic cpu_read(input logic [7:0] a, output sdmac_xfer_pkg::word_t d);
    addr = a;
    rw   = 1'b1;
    cs_  = 1'b0;
    as_  = 1'b0;
    idle_cycles(2);
    d = rdata; // Sampled mid access
    cs_ = 1'b1;
    as_ = 1'b1;
    next_cycle();
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, got);
    assert (got === exp)
    else begin
      $display("ERR %0d ns %s expected 0x%0h got 0x%0h", $time, name, exp, got);
      err_val++;
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    assert (cond)
    else begin
      $display("Check failed at %0d ns: %s", $time, msg);
      err_other++;
    end
  endtask

  // Queue big-endian bytes of a word or only its low half after an A1 start
  task automatic expect_word(input sdmac_xfer_pkg::word_t w, input bit a1_half);
    if (!a1_half) begin
      model_q.push_back(w[31:24]);
      model_q.push_back(w[23:16]);
    end
    model_q.push_back(w[15:8]);
    model_q.push_back(w[7:0]);
  endtask

  // Wait while ISTR shows ff before pushing
  task automatic push_word(input sdmac_xfer_pkg::word_t w);
    sdmac_xfer_pkg::word_t st;
    do cpu_read(sdmac_reg_pkg::istr_addr, st); while (st[1]);
    cpu_write(sdmac_reg_pkg::data_addr, w);
  endtask

  task automatic wait_int_p();
    sdmac_xfer_pkg::word_t st;
    st = '0;
    while (!st[8]) cpu_read(sdmac_reg_pkg::istr_addr, st);
  endtask

  // Clear first so a stale int_p cannot end the wait early
  task automatic wait_done();
    cpu_write(sdmac_reg_pkg::clr_int_addr, '0);
    wait_int_p();
  endtask

  task automatic stop_and_clear();
    cpu_write(sdmac_reg_pkg::sp_dma_addr, '0);
    cpu_write(sdmac_reg_pkg::clr_int_addr, '0);
  endtask

  task automatic compare_bytes();
    check_true(rx_q.size() == model_q.size(),
               $sformatf("received %0d bytes, expected %0d", rx_q.size(), model_q.size()));
    for (int i = 0; i < rx_q.size() && i < model_q.size(); i++) begin
      check_val("scsi_data", model_q[i], rx_q[i]);
    end
    rx_q.delete();
    model_q.delete();
  endtask

  task automatic test_reset_state();
    sdmac_xfer_pkg::word_t r;
    check_val("rdata", 32'd0, rdata); // No access running
    cpu_read(sdmac_reg_pkg::istr_addr, r);
    check_val("istr", istr_exp(0, 0, 0, 0, 1), r);
    cpu_read(sdmac_reg_pkg::cntr_addr, r);
    check_val("cntr", 32'd0, r);
    check_val("int_", 32'd1, int_);
    check_val("preset", 32'd0, preset);
    check_true(rx_q.size() == 0, "scsi_strb seen after reset");
  endtask

  task automatic test_cntr_rw();
    sdmac_xfer_pkg::word_t v;
    sdmac_xfer_pkg::word_t r;
    take_bits(6, v);
    cpu_write(sdmac_reg_pkg::cntr_addr, v);
    cpu_read(sdmac_reg_pkg::cntr_addr, r);
    check_val("cntr", v, r);
    check_val("preset", v[4], preset); // preset is bit 4
    cpu_write(sdmac_reg_pkg::cntr_addr, '0);
  endtask

  task automatic test_streaming();
    sdmac_xfer_pkg::word_t w;
    sdmac_xfer_pkg::word_t st;
    for (int i = 0; i < fifo_depth; i++) begin // Fill with DMA off
      take_bits(32, w);
      expect_word(w, 1'b0);
      cpu_write(sdmac_reg_pkg::data_addr, w);
    end
    cpu_read(sdmac_reg_pkg::istr_addr, st);
    check_val("istr", istr_exp(0, 0, 0, 1, 0), st); // ff shown to host
    rdy_random = 1'b1;
    cpu_write(sdmac_reg_pkg::st_dma_addr, '0);
    for (int i = 0; i < fifo_depth; i++) begin
      take_bits(32, w);
      expect_word(w, 1'b0);
      push_word(w);
    end
    wait_done();
    rdy_random = 1'b0;
    compare_bytes();
    stop_and_clear();
    take_bits(32, w);
    cpu_write(sdmac_reg_pkg::data_addr, w); // Held back with DMA off
    idle_cycles(12);
    check_true(rx_q.size() == 0, "scsi_strb after DMA was stopped");
    cpu_write(sdmac_reg_pkg::flush_addr, '0);
  endtask

  task automatic test_acr_a1();
    sdmac_xfer_pkg::word_t w;
    cpu_write(sdmac_reg_pkg::acr_addr, 32'h0200_0000); // A1 is bit 25
    for (int i = 0; i < 3; i++) begin
      take_bits(32, w);
      expect_word(w, i == 0);
      cpu_write(sdmac_reg_pkg::data_addr, w);
    end
    cpu_write(sdmac_reg_pkg::st_dma_addr, '0);
    wait_done();
    compare_bytes();
    stop_and_clear();
    cpu_write(sdmac_reg_pkg::acr_addr, '0);
  endtask

  task automatic test_flush();
    sdmac_xfer_pkg::word_t w;
    sdmac_xfer_pkg::word_t st;
    for (int i = 0; i < 3; i++) begin
      take_bits(32, w);
      cpu_write(sdmac_reg_pkg::data_addr, w);
    end
    cpu_read(sdmac_reg_pkg::istr_addr, st);
    check_val("istr", istr_exp(0, 0, 0, 0, 0), st);
    cpu_write(sdmac_reg_pkg::flush_addr, '0);
    cpu_read(sdmac_reg_pkg::istr_addr, st);
    check_val("istr", istr_exp(0, 0, 0, 0, 1), st); // Flush over by now
    cpu_write(sdmac_reg_pkg::st_dma_addr, '0);
    idle_cycles(12);
    check_true(rx_q.size() == 0, "bytes sent from a flushed FIFO");
    stop_and_clear();
    cpu_read(sdmac_reg_pkg::istr_addr, st);
    check_val("istr", istr_exp(0, 0, 0, 0, 1), st);
  endtask

  task automatic test_interrupt();
    sdmac_xfer_pkg::word_t w;
    sdmac_xfer_pkg::word_t st;
    cpu_write(sdmac_reg_pkg::cntr_addr, 32'h04); // intena
    for (int i = 0; i < 2; i++) begin
      take_bits(32, w);
      expect_word(w, 1'b0);
      cpu_write(sdmac_reg_pkg::data_addr, w);
    end
    cpu_write(sdmac_reg_pkg::st_dma_addr, '0);
    wait_int_p();
    check_val("int_", 32'd0, int_);
    compare_bytes();
    stop_and_clear();
    cpu_read(sdmac_reg_pkg::istr_addr, st);
    check_val("istr", istr_exp(0, 0, 0, 0, 1), st);
    check_val("int_", 32'd1, int_);
    cpu_write(sdmac_reg_pkg::cntr_addr, '0); // Masked from here
    take_bits(32, w);
    expect_word(w, 1'b0);
    cpu_write(sdmac_reg_pkg::data_addr, w);
    cpu_write(sdmac_reg_pkg::st_dma_addr, '0);
    wait_int_p();
    check_val("int_", 32'd1, int_);
    compare_bytes();
    stop_and_clear();
  endtask

  initial begin
    addr       = '0;
    cs_        = 1'b1;
    as_        = 1'b1;
    rw         = 1'b1;
    wdata      = '0;
    scsi_rdy   = 1'b1;
    lfsr       = 16'd83;
    rdy_random = 1'b0;
    wait (RST_ === 1'b1);
    next_cycle();
    test_reset_state();
    test_cntr_rw();
    test_streaming();
    test_acr_a1();
    test_flush();
    test_interrupt();
    $display("Errors: %0d value, %0d other", err_val, err_other);
    if (err_val + err_other == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: testbench/tb_clock.sv
// ======================================================================
// Clock and reset source for the SDMAC testbench
// 8 ns clock, RST_ held low over the first 3 rising edges
// RST_ is released on a falling edge, clear of the active edge
// ======================================================================
module tb_clock #(
  parameter int half_period = 4 // ns
) (
  output logic ACR_WR,
  output logic RST_
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    ACR_WR = 1'b0;
    forever #(half_period) ACR_WR = ~ACR_WR;
  end

  initial begin
    RST_ = 1'b0;
    repeat (3) @(posedge ACR_WR);
    @(negedge ACR_WR);
    RST_ = 1'b1;
  end

endmodule
